/* Makefile */
# Verilator build and run of the decode stage testbench
TOP := d_stage_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f source/*.sv source/*.svh verif/*.sv verif/*.svh
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* all.f */
+incdir+source
+incdir+verif
source/decode_pkg.sv
source/regfile.sv
source/inst_decoder.sv
source/d_stage.sv
verif/d_stage_tb.sv

/* source/d_stage.sv */
// instruction decode stage
// reads ra and rb from the register file and decodes the instruction in
// parallel, then merges both into the packet handed to execute
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module d_stage (
  input  logic                      clock,
  input  logic                      rst_n,
  input  decode_pkg::r_reg_packet_t r_packet_in,    // write-back port
  input  decode_pkg::f_d_packet_t   f_d_packet_in,  // from fetch
  output decode_pkg::d_s_packet_t   d_packet_out    // to execute
);

  import decode_pkg::*;

  decoder_in_t        dec_in;
  decoder_out_t       dec_out;
  logic [`D_XLEN-1:0] rega_value;
  logic [`D_XLEN-1:0] regb_value;

  assign dec_in = '{inst: f_d_packet_in.inst, valid: f_d_packet_in.valid};

  ////////////////////////////////////////////////////////////
  // register read and write-back
  ////////////////////////////////////////////////////////////

  // source indexes always come from the operate view
  regfile regf_0 (
    .clock   (clock),
    .rst_n   (rst_n),
    .rda_idx (f_d_packet_in.inst.r.rega_idx),
    .rdb_idx (f_d_packet_in.inst.r.regb_idx),
    .wr_en   (r_packet_in.wr_en),
    .wr_idx  (r_packet_in.wr_idx),
    .wr_data (r_packet_in.wr_data),
    .rda_out (rega_value),
    .rdb_out (regb_value)
  );

  inst_decoder decoder_0 (
    .decoder_packet_in  (dec_in),
    .decoder_packet_out (dec_out)
  );

  ////////////////////////////////////////////////////////////
  // outgoing packet
  ////////////////////////////////////////////////////////////

  always_comb begin
    d_packet_out.npc           = f_d_packet_in.npc;   // passed through
    d_packet_out.inst          = f_d_packet_in.inst;  // execute reads disp here
    d_packet_out.rega_value    = rega_value;
    d_packet_out.regb_value    = regb_value;
    d_packet_out.opa_select    = dec_out.opa_select;
    d_packet_out.opb_select    = dec_out.opb_select;
    d_packet_out.alu_func      = dec_out.alu_func;
    d_packet_out.rd_mem        = dec_out.rd_mem;
    d_packet_out.wr_mem        = dec_out.wr_mem;
    d_packet_out.ldl_mem       = dec_out.ldl_mem;
    d_packet_out.stc_mem       = dec_out.stc_mem;
    d_packet_out.cond_branch   = dec_out.cond_branch;
    d_packet_out.uncond_branch = dec_out.uncond_branch;
    d_packet_out.halt          = dec_out.halt;
    d_packet_out.cpuid         = dec_out.cpuid;
    d_packet_out.illegal       = dec_out.illegal;
    d_packet_out.valid         = dec_out.valid;
    d_packet_out.dest_reg_idx  = dec_out.dest_reg_idx;
  end

endmodule

`default_nettype wire

/* source/decode_params.svh */
// decode stage parameters
// datapath width, register file geometry, and the opcode, operate function
// and PAL codes of the integer subset recognised by the decoder
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath and register file geometry
`define D_XLEN       64     // integer register width
`define D_NUM_REGS   32     // architectural registers
`define D_REG_IDX_W  5      // bits of a register index
`define D_ZERO_REG   5'd31  // hardwired zero register

// primary opcodes, inst[31:26]
`define D_OP_PAL     6'h00  // call_pal, function in inst[25:0]
`define D_OP_INTA    6'h10  // integer arithmetic group
`define D_OP_INTL    6'h11  // integer logical group
`define D_OP_INTS    6'h12  // integer shift group
`define D_OP_INTM    6'h13  // integer multiply group
`define D_OP_JSR     6'h1a  // jmp / jsr / ret family
`define D_OP_LDQ     6'h29
`define D_OP_LDQ_L   6'h2b  // load locked
`define D_OP_STQ     6'h2d
`define D_OP_STQ_C   6'h2f  // store conditional
`define D_OP_BR      6'h30
`define D_OP_BSR     6'h34
`define D_OP_CBR_LO  6'h38  // blbc, first integer conditional branch
`define D_OP_CBR_HI  6'h3f  // bgt, last integer conditional branch

// operate function codes, inst[11:5], only unique inside their own group
`define D_FN_ADD     7'h20  // inta addq
`define D_FN_SUB     7'h29  // inta subq
`define D_FN_CMPEQ   7'h2d  // inta cmpeq
`define D_FN_CMPLT   7'h4d  // inta cmplt
`define D_FN_AND     7'h00  // intl and
`define D_FN_BIS     7'h20  // intl bis
`define D_FN_XOR     7'h40  // intl xor
`define D_FN_SLL     7'h39  // ints sll
`define D_FN_SRL     7'h34  // ints srl
`define D_FN_SRA     7'h3c  // ints sra
`define D_FN_MULQ    7'h20  // intm mulq

// PAL function codes
`define D_PAL_HALT   26'h0000555
`define D_PAL_WHAMI  26'h000003c

`endif

/* source/decode_pkg.sv */
// decode stage types
// instruction word views, operand select and ALU encodings, and the
// packets exchanged with fetch, write-back and execute
`default_nettype none

`include "decode_params.svh"

package decode_pkg;

  ////////////////////////////////////////////////////////////
  // instruction word
  ////////////////////////////////////////////////////////////

  // one 32-bit word, read as operate format or memory format
  typedef union packed {
    struct packed {
      logic [5:0]              opcode;
      logic [`D_REG_IDX_W-1:0] rega_idx;   // ra
      logic [`D_REG_IDX_W-1:0] regb_idx;   // rb, literal high bits when lit_flag
      logic [2:0]              lit;        // literal low bits, sbz otherwise
      logic                    lit_flag;   // rb replaced by 8-bit literal
      logic [6:0]              func;
      logic [`D_REG_IDX_W-1:0] rc_idx;     // operate destination
    } r;
    struct packed {
      logic [5:0]              opcode;
      logic [`D_REG_IDX_W-1:0] rega_idx;   // load dest / store source
      logic [`D_REG_IDX_W-1:0] regb_idx;   // base register
      logic [15:0]             disp;       // signed byte displacement
    } m;
  } inst_t;

  ////////////////////////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD   = 5'h00,
    ALU_SUB   = 5'h01,
    ALU_CMPEQ = 5'h02,
    ALU_CMPLT = 5'h03,
    ALU_AND   = 5'h04,
    ALU_BIS   = 5'h05,   // logical or
    ALU_XOR   = 5'h06,
    ALU_SLL   = 5'h07,
    ALU_SRL   = 5'h08,
    ALU_SRA   = 5'h09,
    ALU_MULQ  = 5'h0a
  } alu_func_e;

  // operand a source in execute
  typedef enum logic [1:0] {
    OPA_IS_REGA     = 2'h0,
    OPA_IS_MEM_DISP = 2'h1,  // sign-extended memory displacement
    OPA_IS_NPC      = 2'h2,  // next pc, for branch targets
    OPA_IS_NOT3     = 2'h3   // ~64'h3, masks jump target alignment
  } opa_select_e;

  // operand b source in execute
  typedef enum logic [1:0] {
    OPB_IS_REGB    = 2'h0,
    OPB_IS_ALU_IMM = 2'h1,   // zero-extended 8-bit literal
    OPB_IS_BR_DISP = 2'h2    // branch displacement times 4
  } opb_select_e;

  ////////////////////////////////////////////////////////////
  // stage packets
  ////////////////////////////////////////////////////////////

  // from fetch
  typedef struct packed {
    logic [`D_XLEN-1:0] npc;
    inst_t              inst;
    logic               valid;
  } f_d_packet_t;

  // from write-back, one strobe per write
  typedef struct packed {
    logic                    wr_en;
    logic [`D_REG_IDX_W-1:0] wr_idx;
    logic [`D_XLEN-1:0]      wr_data;
  } r_reg_packet_t;

  typedef struct packed {
    inst_t inst;
    logic  valid;
  } decoder_in_t;

  typedef struct packed {
    opa_select_e             opa_select;
    opb_select_e             opb_select;
    alu_func_e               alu_func;
    logic                    rd_mem;         // load
    logic                    wr_mem;         // store
    logic                    ldl_mem;        // load locked
    logic                    stc_mem;        // store conditional
    logic                    cond_branch;
    logic                    uncond_branch;
    logic                    halt;
    logic                    cpuid;          // whami
    logic                    illegal;
    logic                    valid;          // real instruction in this slot
    logic [`D_REG_IDX_W-1:0] dest_reg_idx;   // zero reg when nothing written
  } decoder_out_t;

  // to execute, decoder fields flattened next to the operands
  typedef struct packed {
    logic [`D_XLEN-1:0]      npc;
    inst_t                   inst;
    logic [`D_XLEN-1:0]      rega_value;
    logic [`D_XLEN-1:0]      regb_value;
    opa_select_e             opa_select;
    opb_select_e             opb_select;
    alu_func_e               alu_func;
    logic                    rd_mem;
    logic                    wr_mem;
    logic                    ldl_mem;
    logic                    stc_mem;
    logic                    cond_branch;
    logic                    uncond_branch;
    logic                    halt;
    logic                    cpuid;
    logic                    illegal;
    logic                    valid;
    logic [`D_REG_IDX_W-1:0] dest_reg_idx;
  } d_s_packet_t;

endpackage

`default_nettype wire

/* source/inst_decoder.sv */
// instruction decoder
// turns one instruction word into operand selects, ALU function, memory and
// branch flags and the destination register; purely combinational
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module inst_decoder (
  input  decode_pkg::decoder_in_t  decoder_packet_in,
  output decode_pkg::decoder_out_t decoder_packet_out
);

  import decode_pkg::*;

  inst_t        inst;
  logic         in_valid;
  logic [25:0]  pal_func;      // call_pal function field
  alu_func_e    op_alu_func;   // operate group ALU mapping
  logic         op_func_ok;    // func known inside its group
  decoder_out_t dec;

  assign inst     = decoder_packet_in.inst;
  assign in_valid = decoder_packet_in.valid;

  // inst[25:0] spans ra, rb and disp of the memory view
  assign pal_func = {inst.m.rega_idx, inst.m.regb_idx, inst.m.disp};

  ////////////////////////////////////////////////////////////
  // operate format function mapping
  ////////////////////////////////////////////////////////////

  // func codes overlap between groups, so decode per opcode
  always_comb begin
    op_alu_func = ALU_ADD;
    op_func_ok  = 1'b1;
    case (inst.r.opcode)
      `D_OP_INTA: begin
        case (inst.r.func)
          `D_FN_ADD:   op_alu_func = ALU_ADD;
          `D_FN_SUB:   op_alu_func = ALU_SUB;
          `D_FN_CMPEQ: op_alu_func = ALU_CMPEQ;
          `D_FN_CMPLT: op_alu_func = ALU_CMPLT;
          default:     op_func_ok  = 1'b0;
        endcase
      end
      `D_OP_INTL: begin
        case (inst.r.func)
          `D_FN_AND: op_alu_func = ALU_AND;
          `D_FN_BIS: op_alu_func = ALU_BIS;
          `D_FN_XOR: op_alu_func = ALU_XOR;
          default:   op_func_ok  = 1'b0;
        endcase
      end
      `D_OP_INTS: begin
        case (inst.r.func)
          `D_FN_SLL: op_alu_func = ALU_SLL;
          `D_FN_SRL: op_alu_func = ALU_SRL;
          `D_FN_SRA: op_alu_func = ALU_SRA;
          default:   op_func_ok  = 1'b0;
        endcase
      end
      `D_OP_INTM: begin
        case (inst.r.func)
          `D_FN_MULQ: op_alu_func = ALU_MULQ;
          default:    op_func_ok  = 1'b0;
        endcase
      end
      default: op_func_ok = 1'b0;  // not an operate opcode
    endcase
  end

  ////////////////////////////////////////////////////////////
  // main decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // quiet defaults, also the whole answer for an empty slot
    dec.opa_select    = OPA_IS_REGA;
    dec.opb_select    = OPB_IS_REGB;
    dec.alu_func      = ALU_ADD;
    dec.rd_mem        = 1'b0;
    dec.wr_mem        = 1'b0;
    dec.ldl_mem       = 1'b0;
    dec.stc_mem       = 1'b0;
    dec.cond_branch   = 1'b0;
    dec.uncond_branch = 1'b0;
    dec.halt          = 1'b0;
    dec.cpuid         = 1'b0;
    dec.illegal       = 1'b0;
    dec.valid         = 1'b0;
    dec.dest_reg_idx  = `D_ZERO_REG;

    if (in_valid) begin
      case (inst.r.opcode) inside
        `D_OP_PAL: begin
          case (pal_func)
            `D_PAL_HALT:  dec.halt    = 1'b1;
            `D_PAL_WHAMI: dec.cpuid   = 1'b1;
            default:      dec.illegal = 1'b1;  // unsupported pal call
          endcase
        end
        `D_OP_INTA, `D_OP_INTL, `D_OP_INTS, `D_OP_INTM: begin
          dec.opa_select   = OPA_IS_REGA;
          dec.opb_select   = inst.r.lit_flag ? OPB_IS_ALU_IMM : OPB_IS_REGB;
          dec.alu_func     = op_alu_func;
          dec.dest_reg_idx = inst.r.rc_idx;
          dec.illegal      = !op_func_ok;
        end
        `D_OP_LDQ, `D_OP_LDQ_L: begin
          dec.opa_select   = OPA_IS_MEM_DISP;   // address = disp + rb
          dec.opb_select   = OPB_IS_REGB;
          dec.alu_func     = ALU_ADD;
          dec.rd_mem       = 1'b1;
          dec.ldl_mem      = (inst.r.opcode == `D_OP_LDQ_L);
          dec.dest_reg_idx = inst.m.rega_idx;
        end
        `D_OP_STQ, `D_OP_STQ_C: begin
          dec.opa_select = OPA_IS_MEM_DISP;
          dec.opb_select = OPB_IS_REGB;
          dec.alu_func   = ALU_ADD;
          dec.wr_mem     = 1'b1;
          if (inst.r.opcode == `D_OP_STQ_C) begin
            dec.stc_mem      = 1'b1;
            dec.dest_reg_idx = inst.m.rega_idx;  // success flag back into ra
          end
        end
        `D_OP_BR, `D_OP_BSR: begin
          dec.opa_select    = OPA_IS_NPC;
          dec.opb_select    = OPB_IS_BR_DISP;
          dec.alu_func      = ALU_ADD;
          dec.uncond_branch = 1'b1;
          dec.dest_reg_idx  = inst.m.rega_idx;  // link register
        end
        [`D_OP_CBR_LO:`D_OP_CBR_HI]: begin
          dec.opa_select  = OPA_IS_NPC;
          dec.opb_select  = OPB_IS_BR_DISP;
          dec.alu_func    = ALU_ADD;
          dec.cond_branch = 1'b1;               // no register written
        end
        `D_OP_JSR: begin
          dec.opa_select    = OPA_IS_NOT3;      // target = rb & ~3
          dec.opb_select    = OPB_IS_REGB;
          dec.alu_func      = ALU_AND;
          dec.uncond_branch = 1'b1;
          dec.dest_reg_idx  = inst.m.rega_idx;
        end
        default: dec.illegal = 1'b1;
      endcase

      // a rejected instruction writes nothing
      if (dec.illegal) begin
        dec.dest_reg_idx = `D_ZERO_REG;
      end
    end

    dec.valid = in_valid && !dec.illegal;
  end

  assign decoder_packet_out = dec;

endmodule

`default_nettype wire

/* source/regfile.sv */
// integer register file
// 32 x 64-bit, two combinational read ports and one clocked write port;
// register 31 reads zero and a same-cycle write is forwarded to the readers
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module regfile (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic [`D_REG_IDX_W-1:0] rda_idx,   // read port a
  input  logic [`D_REG_IDX_W-1:0] rdb_idx,   // read port b
  input  logic                    wr_en,     // one-cycle write strobe
  input  logic [`D_REG_IDX_W-1:0] wr_idx,
  input  logic [`D_XLEN-1:0]      wr_data,
  output logic [`D_XLEN-1:0]      rda_out,
  output logic [`D_XLEN-1:0]      rdb_out
);

  logic [`D_XLEN-1:0] registers [`D_NUM_REGS];

  // zero register never takes a write
  logic wr_ok;

  assign wr_ok = wr_en && (wr_idx != `D_ZERO_REG);

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `D_NUM_REGS; i++) begin
        registers[i] <= '0;              // whole file clears
      end
    end else if (wr_ok) begin
      registers[wr_idx] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // read ports
  ////////////////////////////////////////////////////////////

  // one read port, priority is zero reg, then write bypass, then array
  function automatic logic [`D_XLEN-1:0] read_port(
    input logic [`D_REG_IDX_W-1:0] idx
  );
    logic [`D_XLEN-1:0] word;
    if (idx == `D_ZERO_REG) begin
      word = '0;
    end else if (wr_ok && (wr_idx == idx)) begin
      word = wr_data;                    // write lands this edge, bypass it
    end else begin
      word = registers[idx];
    end
    return word;
  endfunction

  always_comb begin
    rda_out = read_port(rda_idx);
    rdb_out = read_port(rdb_idx);
  end

endmodule

`default_nettype wire

/* verif/decode_model.svh */
// reference model for the decode stage testbench
// expected control fields and register reads, worked out from the decode rules
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// ALU function of an operate instruction, returns 0 when func is not known
function automatic logic operate_alu(input logic [5:0] op, input logic [6:0] fn,
                                     output alu_func_e alu);
  logic known;
  known = 1'b1;
  alu   = ALU_ADD;
  if      (op == `D_OP_INTA && fn == `D_FN_ADD)   alu = ALU_ADD;
  else if (op == `D_OP_INTA && fn == `D_FN_SUB)   alu = ALU_SUB;
  else if (op == `D_OP_INTA && fn == `D_FN_CMPEQ) alu = ALU_CMPEQ;
  else if (op == `D_OP_INTA && fn == `D_FN_CMPLT) alu = ALU_CMPLT;
  else if (op == `D_OP_INTL && fn == `D_FN_AND)   alu = ALU_AND;
  else if (op == `D_OP_INTL && fn == `D_FN_BIS)   alu = ALU_BIS;
  else if (op == `D_OP_INTL && fn == `D_FN_XOR)   alu = ALU_XOR;
  else if (op == `D_OP_INTS && fn == `D_FN_SLL)   alu = ALU_SLL;
  else if (op == `D_OP_INTS && fn == `D_FN_SRL)   alu = ALU_SRL;
  else if (op == `D_OP_INTS && fn == `D_FN_SRA)   alu = ALU_SRA;
  else if (op == `D_OP_INTM && fn == `D_FN_MULQ)  alu = ALU_MULQ;
  else known = 1'b0;
  return known;
endfunction

function automatic decoder_out_t expected_decode(input inst_t inst, input logic valid);
  decoder_out_t e;
  logic [5:0]   op;
  logic [25:0]  pal;
  alu_func_e    fn;
  e              = '0;             // regb / rega / add, no flags
  e.dest_reg_idx = `D_ZERO_REG;
  op             = inst.r.opcode;
  pal            = inst[25:0];
  if (!valid) begin
    return e;                      // empty slot
  end
  if (op == `D_OP_PAL) begin
    e.halt    = (pal == `D_PAL_HALT);
    e.cpuid   = (pal == `D_PAL_WHAMI);
    e.illegal = !(e.halt || e.cpuid);
  end else if (op inside {`D_OP_INTA, `D_OP_INTL, `D_OP_INTS, `D_OP_INTM}) begin
    e.illegal      = !operate_alu(op, inst.r.func, fn);
    e.alu_func     = fn;
    e.opb_select   = inst.r.lit_flag ? OPB_IS_ALU_IMM : OPB_IS_REGB;
    e.dest_reg_idx = inst.r.rc_idx;
  end else if (op == `D_OP_LDQ || op == `D_OP_LDQ_L) begin
    e.opa_select   = OPA_IS_MEM_DISP;
    e.rd_mem       = 1'b1;
    e.ldl_mem      = (op == `D_OP_LDQ_L);
    e.dest_reg_idx = inst.m.rega_idx;
  end else if (op == `D_OP_STQ || op == `D_OP_STQ_C) begin
    e.opa_select = OPA_IS_MEM_DISP;
    e.wr_mem     = 1'b1;
    if (op == `D_OP_STQ_C) begin
      e.stc_mem      = 1'b1;
      e.dest_reg_idx = inst.m.rega_idx;   // success flag
    end
  end else if (op == `D_OP_BR || op == `D_OP_BSR) begin
    e.opa_select    = OPA_IS_NPC;
    e.opb_select    = OPB_IS_BR_DISP;
    e.uncond_branch = 1'b1;
    e.dest_reg_idx  = inst.m.rega_idx;
  end else if (op >= `D_OP_CBR_LO && op <= `D_OP_CBR_HI) begin
    e.opa_select  = OPA_IS_NPC;
    e.opb_select  = OPB_IS_BR_DISP;
    e.cond_branch = 1'b1;
  end else if (op == `D_OP_JSR) begin
    e.opa_select    = OPA_IS_NOT3;
    e.alu_func      = ALU_AND;
    e.uncond_branch = 1'b1;
    e.dest_reg_idx  = inst.m.rega_idx;
  end else begin
    e.illegal = 1'b1;
  end
  if (e.illegal) begin
    e.dest_reg_idx = `D_ZERO_REG;
  end
  e.valid = !e.illegal;
  return e;
endfunction

// read port value: zero reg, then same-cycle write, then stored word
function automatic logic [`D_XLEN-1:0] expected_read(input logic [`D_REG_IDX_W-1:0] idx,
                                                     input logic [`D_XLEN-1:0] stored,
                                                     input r_reg_packet_t wb);
  if (idx == `D_ZERO_REG) begin
    return '0;
  end
  if (wb.wr_en && wb.wr_idx == idx) begin
    return wb.wr_data;
  end
  return stored;
endfunction

`endif

/* verif/d_stage_tb.sv */
// decode stage testbench
// random and directed instructions and write-backs, checked against the
// reference decode model and a shadow copy of the register file
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module d_stage_tb;

  import decode_pkg::*;

  `include "decode_model.svh"

  logic               clock;
  logic               rst_n;
  f_d_packet_t        f_d_in;
  r_reg_packet_t      r_in;
  d_s_packet_t        d_out;
  logic [`D_XLEN-1:0] shadow [`D_NUM_REGS];   // register values seen by the bench
  integer             seed;

  d_stage dut (
    .clock         (clock),
    .rst_n         (rst_n),
    .r_packet_in   (r_in),
    .f_d_packet_in (f_d_in),
    .d_packet_out  (d_out)
  );

  always #10 clock = ~clock;   // 20 ns period

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic compare_controls(input decoder_out_t exp);
    check_word("opa_select", 64'(exp.opa_select), 64'(d_out.opa_select));
    check_word("opb_select", 64'(exp.opb_select), 64'(d_out.opb_select));
    check_word("alu_func", 64'(exp.alu_func), 64'(d_out.alu_func));
    check_word("rd_mem", 64'(exp.rd_mem), 64'(d_out.rd_mem));
    check_word("wr_mem", 64'(exp.wr_mem), 64'(d_out.wr_mem));
    check_word("ldl_mem", 64'(exp.ldl_mem), 64'(d_out.ldl_mem));
    check_word("stc_mem", 64'(exp.stc_mem), 64'(d_out.stc_mem));
    check_word("cond_branch", 64'(exp.cond_branch), 64'(d_out.cond_branch));
    check_word("uncond_branch", 64'(exp.uncond_branch), 64'(d_out.uncond_branch));
    check_word("halt", 64'(exp.halt), 64'(d_out.halt));
    check_word("cpuid", 64'(exp.cpuid), 64'(d_out.cpuid));
    check_word("illegal", 64'(exp.illegal), 64'(d_out.illegal));
    check_word("valid", 64'(exp.valid), 64'(d_out.valid));
    check_word("dest_reg_idx", 64'(exp.dest_reg_idx), 64'(d_out.dest_reg_idx));
  endtask

  // one cycle: drive after the edge, check just before the next one
  task automatic run_cycle(input f_d_packet_t f, input r_reg_packet_t r);
    decoder_out_t exp;
    exp = expected_decode(f.inst, f.valid);
    @(posedge clock);
    #2;
    f_d_in = f;
    r_in   = r;
    #17;
    check_word("rega_value", expected_read(f.inst.r.rega_idx, shadow[f.inst.r.rega_idx], r),
               d_out.rega_value);
    check_word("regb_value", expected_read(f.inst.r.regb_idx, shadow[f.inst.r.regb_idx], r),
               d_out.regb_value);
    check_word("npc", f.npc, d_out.npc);
    check_word("inst", {32'd0, f.inst}, {32'd0, d_out.inst});
    compare_controls(exp);
    if (r.wr_en && r.wr_idx != `D_ZERO_REG) begin
      shadow[r.wr_idx] = r.wr_data;   // lands at the coming edge
    end
  endtask

  task automatic expect_illegal(input inst_t inst);
    f_d_packet_t   f;
    r_reg_packet_t r;
    f = '{npc: {$random(seed), $random(seed)}, inst: inst, valid: 1'b1};
    r = '0;
    run_cycle(f, r);
    check_word("illegal", 64'd1, 64'(d_out.illegal));
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // random instruction from one of the known classes
  task automatic make_inst(output inst_t inst);
    logic [31:0] rnd;
    rnd  = $random(seed);
    inst = $random(seed);   // random register fields and literal
    case (rnd[3:0])
      4'd0:  {inst.r.opcode, inst.r.func} = {`D_OP_INTA, `D_FN_ADD};
      4'd1:  {inst.r.opcode, inst.r.func} = {`D_OP_INTA, `D_FN_SUB};
      4'd2:  {inst.r.opcode, inst.r.func} = {`D_OP_INTA, `D_FN_CMPEQ};
      4'd3:  {inst.r.opcode, inst.r.func} = {`D_OP_INTA, `D_FN_CMPLT};
      4'd4:  {inst.r.opcode, inst.r.func} = {`D_OP_INTL, `D_FN_AND};
      4'd5:  {inst.r.opcode, inst.r.func} = {`D_OP_INTL, `D_FN_BIS};
      4'd6:  {inst.r.opcode, inst.r.func} = {`D_OP_INTL, `D_FN_XOR};
      4'd7:  {inst.r.opcode, inst.r.func} = {`D_OP_INTS, `D_FN_SLL};
      4'd8:  {inst.r.opcode, inst.r.func} = {`D_OP_INTS, `D_FN_SRL};
      4'd9:  {inst.r.opcode, inst.r.func} = {`D_OP_INTS, `D_FN_SRA};
      4'd10: {inst.r.opcode, inst.r.func} = {`D_OP_INTM, `D_FN_MULQ};
      4'd11: inst.r.opcode = `D_OP_JSR;
      4'd12: inst.r.opcode = rnd[5] ? `D_OP_LDQ_L : `D_OP_LDQ;
      4'd13: inst.r.opcode = rnd[5] ? `D_OP_STQ_C : `D_OP_STQ;
      4'd14: begin
        case (rnd[6:5])
          2'd0:    inst.r.opcode = `D_OP_BR;
          2'd1:    inst.r.opcode = `D_OP_BSR;
          default: inst.r.opcode = `D_OP_CBR_LO + {3'b000, rnd[9:7]};   // whole range
        endcase
      end
      default: inst = {`D_OP_PAL, rnd[5] ? `D_PAL_HALT : `D_PAL_WHAMI};
    endcase
  endtask

  // write-back, often aimed at the registers being read
  task automatic make_write(input inst_t inst, output r_reg_packet_t r);
    logic [31:0] rnd;
    rnd       = $random(seed);
    r.wr_en   = rnd[0] | rnd[1];
    r.wr_idx  = rnd[8:4];
    r.wr_data = {$random(seed), $random(seed)};
    case (rnd[11:9])
      3'd0:    r.wr_idx = inst.r.rega_idx;   // forward to port a
      3'd1:    r.wr_idx = inst.r.regb_idx;   // forward to port b
      3'd2:    r.wr_idx = `D_ZERO_REG;
      default: ;
    endcase
  endtask

  initial begin : watchdog
    for (int c = 0; c < 1000; c++) begin
      @(posedge clock);
    end
    fail_run("the run did not finish within 1000 clock cycles");
  end

  initial begin : stimulus
    f_d_packet_t   f;
    r_reg_packet_t r;
    inst_t         inst;
    logic [31:0]   rnd;
    seed   = 28470;
    clock  = 1'b0;
    rst_n  = 1'b0;
    f_d_in = '0;
    r_in   = '0;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    for (int c = 0; c < 4; c++) begin
      @(posedge clock);
    end
    #2;
    rst_n = 1'b1;

    // every index reads zero after reset, on both ports
    for (int i = 0; i < `D_NUM_REGS; i++) begin
      f                 = '0;
      f.inst.r.rega_idx = 5'(i);
      f.inst.r.regb_idx = 5'd31 - 5'(i);
      run_cycle(f, '0);
    end

    // zero register drops a write, then a same-cycle forward on port b
    f                 = '0;
    f.inst.r.rega_idx = `D_ZERO_REG;
    f.inst.r.regb_idx = 5'd7;
    r                 = '{wr_en: 1'b1, wr_idx: `D_ZERO_REG, wr_data: '1};
    run_cycle(f, r);
    r = '{wr_en: 1'b1, wr_idx: 5'd7, wr_data: 64'h0123_4567_89ab_cdef};
    run_cycle(f, r);
    r.wr_en = 1'b0;
    run_cycle(f, r);   // stored value now

    // random instructions with random write-backs
    for (int n = 0; n < 300; n++) begin
      make_inst(inst);
      rnd = $random(seed);
      f   = '{npc: {$random(seed), $random(seed)}, inst: inst, valid: rnd[2:0] != 3'd0};
      make_write(inst, r);
      run_cycle(f, r);
    end

    // empty slots
    for (int n = 0; n < 30; n++) begin
      make_inst(inst);
      f = '{npc: {$random(seed), $random(seed)}, inst: inst, valid: 1'b0};
      make_write(inst, r);
      run_cycle(f, r);
    end

    // unknown opcodes, operate functions and PAL codes
    for (int i = 0; i < 12; i++) begin
      inst = $random(seed);
      case (i)
        0:       inst.r.opcode = 6'h01;
        1:       inst.r.opcode = 6'h08;
        2:       inst.r.opcode = 6'h14;
        3:       inst.r.opcode = 6'h1b;
        4:       inst.r.opcode = 6'h28;
        5:       inst.r.opcode = 6'h2e;
        6:       {inst.r.opcode, inst.r.func} = {`D_OP_INTA, 7'h7f};
        7:       {inst.r.opcode, inst.r.func} = {`D_OP_INTL, 7'h01};
        8:       {inst.r.opcode, inst.r.func} = {`D_OP_INTS, 7'h00};
        9:       {inst.r.opcode, inst.r.func} = {`D_OP_INTM, 7'h00};
        10:      inst = {`D_OP_PAL, 26'h0000001};
        default: inst = {`D_OP_PAL, 26'h3ffffff};
      endcase
      expect_illegal(inst);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
